/* verilog.f */
+incdir+dv
src/isaPkg.sv
src/ctrlPkg.sv
src/ctrlBusIf.sv
src/controlUnit.sv
src/aluCore.sv
src/pcUnit.sv
src/regFile.sv
src/wbSelect.sv
src/cpuTop.sv
dv/cpuTb.sv

/* Bender.yml */
package:
  name: cpu16

sources:
  - src/isaPkg.sv
  - src/ctrlPkg.sv
  - src/ctrlBusIf.sv
  - src/controlUnit.sv
  - src/aluCore.sv
  - src/pcUnit.sv
  - src/regFile.sv
  - src/wbSelect.sv
  - src/cpuTop.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/cpuTb.sv

/* dv/cpuModel.svh */
//////////////////////////////
// ISA reference model
// model state, rotate/reverse helpers
// one-instruction step function
//////////////////////////////
`ifndef cpuModelSvh
`define cpuModelSvh

typedef struct {
   logic [wordW-1:0] pc;
   logic [wordW-1:0] regs [8];
   logic [wordW-1:0] mem [256];   // words, byte address bits 8:1
   logic halted;
   logic err;
   logic stValid;                 // this step stored a word
   logic [wordW-1:0] stAddr;
   logic [wordW-1:0] stData;
} modelStateT;

function automatic logic [wordW-1:0] rotLeft(logic [wordW-1:0] x, logic [3:0] n);
   return (x << n) | (x >> (wordW - n));
endfunction

function automatic logic [wordW-1:0] rotRight(logic [wordW-1:0] x, logic [3:0] n);
   return (x >> n) | (x << (wordW - n));
endfunction

function automatic logic [wordW-1:0] bitReverse(logic [wordW-1:0] x);
   logic [wordW-1:0] r;
   for (int i = 0; i < wordW; i++)
      r[i] = x[wordW-1-i];
   return r;
endfunction

// shared by register and immediate forms, fn picks the operation
function automatic logic [wordW-1:0] opResult(logic shift, logic [1:0] fn,
                                              logic [wordW-1:0] a, logic [wordW-1:0] b);
   if (shift) begin
      case (fn)
         2'd0: return rotLeft(a, b[3:0]);
         2'd1: return a << b[3:0];
         2'd2: return rotRight(a, b[3:0]);
         default: return a >> b[3:0];
      endcase
   end
   case (fn)
      2'd0: return a + b;
      2'd1: return b - a;                // subtract is b minus a
      2'd2: return a ^ b;
      default: return a & ~b;
   endcase
endfunction

function automatic modelStateT cpuStep(modelStateT s, logic [wordW-1:0] ins);
   modelStateT n;
   opcodeT op;
   logic [wordW-1:0] rs;
   logic [wordW-1:0] rt;
   logic [wordW-1:0] i5s;
   logic [wordW-1:0] i8s;
   logic [wordW-1:0] pcInc;
   logic [wordW-1:0] addr;
   logic [wordW-1:0] res;
   logic [wordW:0] wide;
   logic [2:0] dst;
   logic wr;
   n = s;
   n.stValid = 1'b0;
   if (s.halted)
      return n;                          // frozen state
   op = opcodeT'(ins[15:11]);
   rs = s.regs[ins[10:8]];
   rt = s.regs[ins[7:5]];
   i5s = {{11{ins[4]}}, ins[4:0]};
   i8s = {{8{ins[7]}}, ins[7:0]};
   pcInc = s.pc + 16'd2;
   addr = rs + i5s;                      // LD/ST/STU address
   wide = {1'b0, rs} + {1'b0, rt};       // SCO carry
   n.pc = pcInc;
   res = '0;
   dst = ins[4:2];                       // rd unless changed
   wr = 1'b1;
   case (op)
      opHalt: begin
         n.halted = 1'b1;
         wr = 1'b0;
      end
      opNop, opSiic, opRti: wr = 1'b0;
      opAddi, opSubi, opXori, opAndni, opRoli, opSlli, opRori, opSrli: begin
         res = opResult(op inside {[opRoli:opSrli]}, ins[12:11], rs,
                        (op inside {opAddi, opSubi}) ? i5s : {11'b0, ins[4:0]});
         dst = ins[7:5];
      end
      opShiftR, opArithR: res = opResult(op == opShiftR, ins[1:0], rs, rt);
      opSt, opStu: begin
         n.stValid = 1'b1;
         n.stAddr = addr;
         n.stData = rt;
         n.mem[addr[8:1]] = rt;
         res = addr;                     // STU base update
         dst = ins[10:8];
         wr = (op == opStu);
      end
      opLd: begin
         res = s.mem[addr[8:1]];
         dst = ins[7:5];
      end
      opBeqz, opBnez, opBltz, opBgez: begin
         wr = 1'b0;
         if ((op == opBeqz && rs == 0) || (op == opBnez && rs != 0) ||
             (op == opBltz && rs[15]) || (op == opBgez && !rs[15]))
            n.pc = pcInc + i8s;
      end
      opJ, opJal, opJr, opJalr: begin
         n.pc = (op inside {opJ, opJal}) ? pcInc + {{5{ins[10]}}, ins[10:0]} : rs + i8s;
         res = pcInc;                    // link value
         dst = 3'd7;
         wr = (op inside {opJal, opJalr});
      end
      opLbi, opSlbi: begin
         res = (op == opLbi) ? i8s : {rs[7:0], ins[7:0]};
         dst = ins[10:8];
      end
      opBtr: res = bitReverse(rs);
      opSeq: res = wordW'(rs == rt);
      opSlt: res = wordW'($signed(rs) < $signed(rt));
      opSle: res = wordW'($signed(rs) <= $signed(rt));
      opSco: res = wordW'(wide[wordW]);
      default: begin
         n.halted = 1'b1;                // illegal opcode
         n.err = 1'b1;
         wr = 1'b0;
      end
   endcase
   if (wr)
      n.regs[dst] = res;
   return n;
endfunction

`endif

/* dv/cpuTb.sv */
//////////////////////////////
// core testbench
// clock, reset, memory models, program
// model compare process, check tasks
//////////////////////////////
`timescale 1ns/100ps

module cpuTb import isaPkg::*; ();

   localparam logic [wordW-1:0] resetPc = 16'h0020;
   localparam int haltTimeout = 600;   // cycles
   localparam int holdCycles = 6;      // cycles watched after halt

   `include "cpuModel.svh"

   logic clk;
   logic rst;
   logic [wordW-1:0] instrAddr;
   logic [wordW-1:0] instr;
   logic [wordW-1:0] dmemAddr;
   logic [wordW-1:0] dmemWrData;
   logic dmemWrEn;
   logic [wordW-1:0] dmemRdData;
   logic halted;
   logic err;

   logic [wordW-1:0] imem [256];
   logic [wordW-1:0] dmem [256];
   logic [wordW-1:0] progQ [$];
   int seed;
   modelStateT mState;
   modelStateT nextState;

   cpuTop #(.resetPc(resetPc)) dut0 (
      .clk(clk), .rst(rst), .instrAddr(instrAddr), .instr(instr), .dmemAddr(dmemAddr),
      .dmemWrData(dmemWrData), .dmemWrEn(dmemWrEn), .dmemRdData(dmemRdData),
      .halted(halted), .err(err)
   );

   always #10 clk = ~clk;

   assign instr = imem[instrAddr[8:1]];       // combinational fetch
   assign dmemRdData = dmem[dmemAddr[8:1]];

   always @(posedge clk) begin
      if (dmemWrEn)
         dmem[dmemAddr[8:1]] <= dmemWrData;
   end

   task automatic checkWord(input string name, input logic [wordW-1:0] expVal,
                            input logic [wordW-1:0] actVal);
      if (actVal !== expVal) begin
         $display("ERROR %s expected %h actual %h", name, expVal, actVal);
         $display("CHECKS FAILED");
         $fatal(1, "mismatch on a word value");
      end
   endtask

   task automatic checkFlag(input string name, input logic expVal, input logic actVal);
      if (actVal !== expVal) begin
         $display("ERROR %s expected %b actual %b", name, expVal, actVal);
         $display("CHECKS FAILED");
         $fatal(1, "mismatch on a status flag");
      end
   endtask

   function automatic logic [wordW-1:0] shortImm(logic [4:0] op, int rs, int rt, int imm);
      return {op, rs[2:0], rt[2:0], imm[4:0]};
   endfunction

   function automatic logic [wordW-1:0] longImm(logic [4:0] op, int rs, int imm);
      return {op, rs[2:0], imm[7:0]};
   endfunction

   function automatic logic [wordW-1:0] regForm(logic [4:0] op, int rs, int rt, int rd,
                                                int fn);
      return {op, rs[2:0], rt[2:0], rd[2:0], fn[1:0]};
   endfunction

   function automatic logic [wordW-1:0] jumpForm(logic [4:0] op, int imm);
      return {op, imm[10:0]};
   endfunction

   function automatic logic [wordW-1:0] nextAddr();
      return resetPc + wordW'(2 * progQ.size());
   endfunction

   task automatic emit(input logic [wordW-1:0] ins);
      progQ.push_back(ins);
   endtask

   task automatic loadConst(input int r, input logic [wordW-1:0] v);
      emit(longImm(opLbi, r, v[15:8]));
      emit(longImm(opSlbi, r, v[7:0]));
   endtask

   task automatic loadRand(input int r);
      logic [wordW-1:0] v;
      v = $random(seed);
      loadConst(r, v);
   endtask

   task automatic storeReg(input int r);
      emit(shortImm(opStu, 6, r, 2));   // store at r6+2, r6 moves on
   endtask

   task automatic buildProgram();
      int v;
      int tgt;
      loadConst(6, 16'h0100);           // store pointer
      loadRand(1);
      loadRand(2);
      for (int k = 0; k < 4; k++) begin
         emit(regForm(opArithR, 1, 2, 3, k));   // add sub xor andn
         storeReg(3);
         v = $random(seed);
         emit(shortImm(5'(opAddi + k), 1, 3, v));
         storeReg(3);
         emit(regForm(5'(opSeq + k), 1, 2, 3, 0));
         storeReg(3);
         emit(regForm(5'(opSeq + k), 2, 1, 3, 0));
         storeReg(3);
         emit(regForm(5'(opSeq + k), 2, 2, 3, 0));  // equal operands
         storeReg(3);
      end
      emit(regForm(opBtr, 1, 0, 3, 0));
      storeReg(3);
      v = $random(seed);
      emit(longImm(opLbi, 3, v));
      storeReg(3);
      loadRand(4);                      // shift amount in low bits
      for (int k = 0; k < 4; k++) begin
         emit(regForm(opShiftR, 1, 4, 3, k));   // rol sll ror srl
         storeReg(3);
         v = $random(seed);
         emit(shortImm(5'(opRoli + k), 2, 3, v));
         storeReg(3);
      end
      emit(longImm(opLbi, 5, 0));
      emit(longImm(opBeqz, 5, 2));      // taken
      emit(longImm(opLbi, 3, 8'h11));
      emit(longImm(opBltz, 5, 2));      // not taken
      emit(longImm(opLbi, 3, 8'h22));
      emit(longImm(opBnez, 5, 2));      // not taken on zero
      emit(longImm(opLbi, 3, 8'h2a));
      emit(longImm(opLbi, 5, 5));
      emit(longImm(opBnez, 5, 2));      // taken
      emit(longImm(opLbi, 3, 8'h33));
      emit(longImm(opBeqz, 5, 2));      // not taken
      emit(longImm(opLbi, 4, 8'h44));
      emit(longImm(opLbi, 5, -3));
      emit(longImm(opBltz, 5, 2));      // taken
      emit(longImm(opLbi, 3, 8'h55));
      emit(longImm(opBgez, 5, 2));      // not taken
      emit(longImm(opLbi, 4, 8'h66));
      storeReg(3);
      storeReg(4);
      emit(longImm(opLbi, 5, 2));       // countdown loop
      emit(shortImm(opAddi, 5, 5, -1));
      emit(longImm(opBgez, 5, -4));     // back to the addi
      storeReg(5);
      emit(jumpForm(opJal, 2));
      emit(longImm(opLbi, 3, 8'h77));
      storeReg(7);
      emit(jumpForm(opJ, 2));
      emit(longImm(opLbi, 3, 8'h78));
      tgt = nextAddr() + 8;
      loadConst(5, tgt);
      emit(longImm(opJalr, 5, 0));
      emit(longImm(opLbi, 3, 8'h79));
      storeReg(7);
      tgt = nextAddr() + 8;
      loadConst(5, tgt - 4);
      emit(longImm(opJr, 5, 4));
      emit(longImm(opLbi, 3, 8'h7a));
      storeReg(3);
      emit(shortImm(opLd, 6, 3, 0));    // last stored word
      emit(shortImm(opLd, 6, 4, -4));
      storeReg(3);
      storeReg(4);
      emit(shortImm(opSt, 6, 1, 6));
      emit(shortImm(opLd, 6, 2, 6));
      storeReg(2);
      emit(shortImm(opLd, 0, 3, 10));   // untouched fill word
      storeReg(3);
      emit(jumpForm(opNop, 0));
      emit(jumpForm(opSiic, 0));
      emit(jumpForm(opRti, 0));
      emit(jumpForm(opHalt, 0));
      emit(shortImm(opSt, 6, 1, 0));    // after halt, no store
      emit(longImm(opLbi, 6, 0));
   endtask

   // model steps once per cycle, DUT state sampled mid-cycle
   always @(negedge clk) begin
      if (!rst) begin
         nextState = cpuStep(mState, imem[mState.pc[8:1]]);
         checkWord($sformatf("fetch at %h", mState.pc), mState.pc, instrAddr);
         checkFlag($sformatf("store enable at %h", mState.pc), nextState.stValid, dmemWrEn);
         if (nextState.stValid) begin
            checkWord($sformatf("store address at %h", mState.pc), nextState.stAddr,
                      dmemAddr);
            checkWord($sformatf("store data at %h", mState.pc), nextState.stData,
                      dmemWrData);
         end
         checkFlag($sformatf("halted at %h", mState.pc), mState.halted, halted);
         checkFlag($sformatf("err at %h", mState.pc), mState.err, err);
         mState = nextState;
      end
   end

   initial begin
      int cycles;
      clk = 1'b0;
      rst = 1'b1;
      seed = 35;
      for (int i = 0; i < 256; i++) begin
         imem[i] = {5'(opNop), 11'(i)};        // nop, address in spare bits
         dmem[i] = {8'(i), ~8'(i)} ^ 16'hA55A;
      end
      buildProgram();
      foreach (progQ[i])
         imem[(resetPc >> 1) + i] = progQ[i];
      mState.pc = resetPc;
      mState.regs = '{default: '0};
      mState.mem = dmem;
      mState.halted = 1'b0;
      mState.err = 1'b0;
      mState.stValid = 1'b0;
      mState.stAddr = '0;
      mState.stData = '0;
      @(negedge clk);                          // first reset edge done
      checkWord("reset pc", resetPc, instrAddr);
      checkFlag("reset store enable", 1'b0, dmemWrEn);
      checkFlag("reset halted", 1'b0, halted);
      checkFlag("reset err", 1'b0, err);
      repeat (2) @(posedge clk);
      rst <= 1'b0;
      cycles = 0;
      while (!halted && cycles < haltTimeout) begin
         @(negedge clk);
         cycles++;
      end
      if (!halted) begin
         $display("core did not halt within %0d cycles", haltTimeout);
         $display("CHECKS FAILED");
         $fatal(1, "halt timeout");
      end
      for (int i = 0; i < holdCycles; i++)
         @(negedge clk);                       // pc and stores stay frozen
      @(posedge clk);
      for (int i = 0; i < 256; i++)
         checkWord($sformatf("data word %0d", i), mState.mem[i], dmem[i]);
      checkWord("pc after halt", mState.pc, instrAddr);
      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

/* src/cpuTop.sv */
//////////////////////////////
// single-cycle core top
// decoder, ALU, pc, registers, writeback
//////////////////////////////
`timescale 1ns/100ps

module cpuTop import isaPkg::*, ctrlPkg::*; #(
   parameter logic [wordW-1:0] resetPc = '0
) (
   input  logic             clk,
   input  logic             rst,
   output logic [wordW-1:0] instrAddr,
   input  logic [wordW-1:0] instr,
   output logic [wordW-1:0] dmemAddr,
   output logic [wordW-1:0] dmemWrData,
   output logic             dmemWrEn,
   input  logic [wordW-1:0] dmemRdData,
   output logic             halted,
   output logic             err
);

   logic [wordW-1:0] rsData;
   logic [wordW-1:0] rtData;
   logic [wordW-1:0] aluOut;
   logic [wordW-1:0] pcCur;
   logic [wordW-1:0] pcInc;
   aluFlagsT flags;
   logic haltReq;
   logic illegal;
   logic wrEn;
   logic [regAddrW-1:0] wrAddr;
   logic [wordW-1:0] wrData;

   ctrlBusIf ctrlBus ();

   controlUnit ctrl0 (.instr(instr), .ctrl(ctrlBus.ctrl), .haltReq(haltReq),
                      .illegal(illegal));

   aluCore alu0 (.instr(instr), .rsData(rsData), .rtData(rtData), .alu(ctrlBus.alu),
                 .aluOut(aluOut), .flags(flags));

   pcUnit #(.resetPc(resetPc)) pc0 (
      .clk(clk), .rst(rst), .instr(instr), .aluOut(aluOut), .flags(flags),
      .pc(ctrlBus.pc), .haltReq(haltReq), .illegal(illegal), .pcCur(pcCur),
      .pcInc(pcInc), .halted(halted), .err(err)
   );

   regFile rf0 (
      .clk(clk), .rst(rst), .rsAddr(instr[rsMsb:rsLsb]), .rtAddr(instr[rtMsb:rtLsb]),
      .rsData(rsData), .rtData(rtData), .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData)
   );

   wbSelect wb0 (
      .instr(instr), .wb(ctrlBus.wb), .aluOut(aluOut), .flags(flags),
      .memRdData(dmemRdData), .pcInc(pcInc), .halted(halted), .wrEn(wrEn),
      .wrAddr(wrAddr), .wrData(wrData)
   );

   assign instrAddr = pcCur;
   assign dmemAddr = aluOut;                          // rs + sext(imm5)
   assign dmemWrData = ctrlBus.stuSel ? rtData : rsData;
   assign dmemWrEn = ctrlBus.memWrt & !halted & !rst; // no store while in reset

endmodule

/* src/wbSelect.sv */
//////////////////////////////
// writeback select
// target register, SLBI merge, set result, data mux
//////////////////////////////
`timescale 1ns/100ps

module wbSelect import isaPkg::*, ctrlPkg::*; (
   input  logic [wordW-1:0]    instr,
   ctrlBusIf.wb                wb,
   input  logic [wordW-1:0]    aluOut,
   input  aluFlagsT            flags,
   input  logic [wordW-1:0]    memRdData,
   input  logic [wordW-1:0]    pcInc,
   input  logic                halted,
   output logic                wrEn,
   output logic [regAddrW-1:0] wrAddr,
   output logic [wordW-1:0]    wrData
);

   logic [wordW-1:0] aluRev;   // BTR, rs mirrored
   logic isBtr;
   logic setBit;

   assign isBtr = (instr[opMsb:opLsb] == opBtr);

   always_comb begin
      for (int i = 0; i < wordW; i++)
         aluRev[i] = aluOut[wordW-1-i];
   end

   always_comb begin
      case (wb.regDest)
         dstRs:   wrAddr = instr[rsMsb:rsLsb];
         dstRt:   wrAddr = instr[rtMsb:rtLsb];
         dstRd:   wrAddr = instr[rdMsb:rdLsb];
         default: wrAddr = '1;              // R7 link
      endcase
   end

   always_comb begin
      case (instr[opLsb+1:opLsb])          // SEQ, SLT, SLE, SCO
         2'b00:   setBit = flags.zero;
         2'b01:   setBit = flags.sign;
         2'b10:   setBit = flags.zero | flags.sign;
         default: setBit = flags.carry;
      endcase
      case (wb.wbSrc)
         wbPcInc: wrData = pcInc;
         wbMem:   wrData = memRdData;
         wbImm8:  wrData = wb.slbiOp ? {aluOut[wordW-9:0], instr[imm8Msb:0]}
                                     : {{(wordW-8){instr[imm8Msb]}}, instr[imm8Msb:0]};
         default: wrData = isBtr ? aluRev : aluOut;
      endcase
      if (wb.setOp)
         wrData = {{(wordW-1){1'b0}}, setBit};
   end

   assign wrEn = wb.regWrt & !halted;

endmodule

/* src/regFile.sv */
//////////////////////////////
// register file, 8 x 16
// two async reads, one sync write
//////////////////////////////
`timescale 1ns/100ps

module regFile import isaPkg::*; (
   input  logic                clk,
   input  logic                rst,
   input  logic [regAddrW-1:0] rsAddr,
   input  logic [regAddrW-1:0] rtAddr,
   output logic [wordW-1:0]    rsData,
   output logic [wordW-1:0]    rtData,
   input  logic                wrEn,
   input  logic [regAddrW-1:0] wrAddr,
   input  logic [wordW-1:0]    wrData
);

   logic [wordW-1:0] regs [2**regAddrW];

   always_ff @(posedge clk) begin
      if (rst)
         regs <= '{default: '0};      // all registers read zero
      else if (wrEn)
         regs[wrAddr] <= wrData;
   end

   // reads see the old value during a write cycle
   assign rsData = regs[rsAddr];
   assign rtData = regs[rtAddr];

endmodule

/* src/pcUnit.sv */
//////////////////////////////
// program counter
// pc adder, branch test, next pc, halt state
//////////////////////////////
`timescale 1ns/100ps

module pcUnit import isaPkg::*, ctrlPkg::*; #(
   parameter logic [wordW-1:0] resetPc = '0
) (
   input  logic             clk,
   input  logic             rst,
   input  logic [wordW-1:0] instr,
   input  logic [wordW-1:0] aluOut,   // JR/JALR target
   input  aluFlagsT         flags,
   ctrlBusIf.pc             pc,
   input  logic             haltReq,
   input  logic             illegal,
   output logic [wordW-1:0] pcCur,
   output logic [wordW-1:0] pcInc,    // also the link value
   output logic             halted,
   output logic             err
);

   logic [wordW-1:0] imm8Ext;
   logic [wordW-1:0] imm11Ext;
   logic [wordW-1:0] pcTarget;
   logic [wordW-1:0] pcNext;
   logic condMet;

   assign pcInc = pcCur + wordW'(2);
   assign imm8Ext = {{(wordW-8){instr[imm8Msb]}}, instr[imm8Msb:0]};
   assign imm11Ext = {{(wordW-11){instr[imm11Msb]}}, instr[imm11Msb:0]};
   assign pcTarget = pcInc + (pc.immSrc ? imm11Ext : imm8Ext);

   always_comb begin
      case (pc.brchCond)
         condSco:  condMet = flags.carry;
         condEq:   condMet = flags.zero;
         condGez:  condMet = !flags.sign;
         condLtz:  condMet = flags.sign;
         condNez:  condMet = !flags.zero;
         condLe:   condMet = flags.zero | flags.sign;
         condJump: condMet = 1'b1;
         default:  condMet = 1'b0;
      endcase
   end

   assign pcNext = pc.aluPc ? aluOut : condMet ? pcTarget : pcInc;

   always_ff @(posedge clk) begin
      if (rst) begin
         pcCur <= resetPc;
         halted <= 1'b0;
         err <= 1'b0;
      end else if (!halted) begin     // frozen once halted
         pcCur <= pcNext;
         if (haltReq | illegal)
            halted <= 1'b1;
         if (illegal)
            err <= 1'b1;
      end
   end

endmodule

/* src/aluCore.sv */
//////////////////////////////
// ALU with operand select
// immediate extension, add/logic/shift, flags
//////////////////////////////
`timescale 1ns/100ps

module aluCore import isaPkg::*, ctrlPkg::*; (
   input  logic [wordW-1:0] instr,
   input  logic [wordW-1:0] rsData,
   input  logic [wordW-1:0] rtData,
   ctrlBusIf.alu            alu,
   output logic [wordW-1:0] aluOut,
   output aluFlagsT         flags
);

   logic [wordW-1:0] imm5Ext;
   logic [wordW-1:0] imm8Ext;
   logic [wordW-1:0] opB;       // selected B before inversion
   logic [wordW-1:0] inA;
   logic [wordW-1:0] inB;
   logic [wordW-1:0] sum;
   logic carryOut;
   logic overflow;
   logic [$clog2(wordW)-1:0] shAmt;
   logic [2*wordW-1:0] rolDbl;  // doubled word shifted left
   logic [2*wordW-1:0] rorDbl;  // doubled word shifted right

   assign imm5Ext = alu.zeroSel ? {{(wordW-5){1'b0}}, instr[imm5Msb:0]}
                                : {{(wordW-5){instr[imm5Msb]}}, instr[imm5Msb:0]};
   assign imm8Ext = alu.zeroSel ? {{(wordW-8){1'b0}}, instr[imm8Msb:0]}
                                : {{(wordW-8){instr[imm8Msb]}}, instr[imm8Msb:0]};

   always_comb begin
      case (alu.bSrc)
         bReg:    opB = rtData;
         bImm5:   opB = imm5Ext;
         bImm8:   opB = imm8Ext;
         default: opB = '0;       // branches look at rs alone
      endcase
   end

   assign inA = alu.invA ? ~rsData : rsData;
   assign inB = alu.invB ? ~opB : opB;
   assign {carryOut, sum} = {1'b0, inA} + {1'b0, inB} + (wordW+1)'(alu.Cin);
   assign overflow = (inA[wordW-1] == inB[wordW-1]) & (sum[wordW-1] != inA[wordW-1]);

   assign shAmt = opB[$clog2(wordW)-1:0];  // low four bits only
   assign rolDbl = {rsData, rsData} << shAmt;
   assign rorDbl = {rsData, rsData} >> shAmt;

   always_comb begin
      case (alu.aluOp)
         aluXor:  aluOut = inA ^ inB;
         aluAndn: aluOut = inA & inB;   // B already inverted
         aluRol:  aluOut = rolDbl[2*wordW-1:wordW];
         aluSll:  aluOut = rsData << shAmt;
         aluRor:  aluOut = rorDbl[wordW-1:0];
         aluSrl:  aluOut = rsData >> shAmt;
         default: aluOut = sum;
      endcase
   end

   assign flags.zero = (aluOut == '0);
   assign flags.sign = (alu.aluOp == aluAdd) ? sum[wordW-1] ^ overflow : aluOut[wordW-1];
   assign flags.carry = carryOut;

endmodule

/* src/controlUnit.sv */
//////////////////////////////
// instruction decoder
// control word, halt request, illegal flag
//////////////////////////////
`timescale 1ns/100ps

module controlUnit import isaPkg::*, ctrlPkg::*; (
   input  logic [wordW-1:0] instr,
   ctrlBusIf.ctrl           ctrl,
   output logic             haltReq,  // HALT seen
   output logic             illegal   // opcode not decodable
);

   opcodeT op;
   logic [1:0] fn;      // function bits, shared by I and R forms
   logic fnValid;       // ALU op taken from fn
   logic shiftGrp;      // fn picks a shift, not arithmetic

   assign op = opcodeT'(instr[opMsb:opLsb]);

   always_comb begin
      ctrl.aluOp = aluAdd;       // safe defaults, nothing written
      ctrl.Cin = 1'b0;
      ctrl.invA = 1'b0;
      ctrl.invB = 1'b0;
      ctrl.bSrc = bReg;
      ctrl.zeroSel = 1'b0;
      ctrl.brchCond = condNone;
      ctrl.immSrc = 1'b0;
      ctrl.aluPc = 1'b0;
      ctrl.regWrt = 1'b0;
      ctrl.wbSrc = wbAlu;
      ctrl.regDest = dstRt;
      ctrl.setOp = 1'b0;
      ctrl.slbiOp = 1'b0;
      ctrl.memWrt = 1'b0;
      ctrl.stuSel = 1'b0;
      haltReq = 1'b0;
      illegal = 1'b0;
      fn = op[1:0];              // immediate forms encode fn in opcode
      fnValid = 1'b0;
      shiftGrp = op[4];          // 101xx shifts, 010xx arithmetic
      case (op)
         opHalt: haltReq = 1'b1;
         opNop, opSiic, opRti: begin
         end
         opAddi, opSubi, opXori, opAndni, opRoli, opSlli, opRori, opSrli: begin
            ctrl.regWrt = 1'b1;
            ctrl.bSrc = bImm5;
            ctrl.zeroSel = !(op inside {opAddi, opSubi});  // only add/sub sign extend
            fnValid = 1'b1;
         end
         opShiftR, opArithR: begin
            ctrl.regWrt = 1'b1;
            ctrl.regDest = dstRd;
            fn = instr[fnMsb:fnLsb];
            fnValid = 1'b1;
            shiftGrp = (op == opShiftR);
         end
         opSt, opLd, opStu: begin
            ctrl.bSrc = bImm5;          // rs + sext(imm5)
            ctrl.memWrt = (op != opLd);
            ctrl.stuSel = (op != opLd);
            ctrl.regWrt = (op != opSt);
            ctrl.wbSrc = (op == opLd) ? wbMem : wbAlu;
            ctrl.regDest = (op == opStu) ? dstRs : dstRt;  // STU updates base
         end
         opBeqz, opBnez, opBltz, opBgez: begin
            ctrl.bSrc = bZero;          // flags describe rs alone
            ctrl.brchCond = brchCondT'({op[1] ^ op[0], !(op[1] ^ op[0]), op[0]});
         end
         opJ, opJal, opJr, opJalr: begin
            ctrl.brchCond = condJump;
            ctrl.immSrc = !op[0];       // J/JAL add imm11 to pc
            ctrl.aluPc = op[0];         // JR/JALR take rs + imm8
            ctrl.bSrc = bImm8;
            ctrl.regWrt = op[1];        // link forms
            ctrl.wbSrc = wbPcInc;
            ctrl.regDest = dstR7;
         end
         opLbi, opSlbi: begin
            ctrl.regWrt = 1'b1;
            ctrl.wbSrc = wbImm8;
            ctrl.regDest = dstRs;
            ctrl.bSrc = bZero;          // ALU passes rs for the merge
            ctrl.slbiOp = (op == opSlbi);
         end
         opBtr: begin
            ctrl.regWrt = 1'b1;
            ctrl.regDest = dstRd;
            ctrl.bSrc = bZero;          // rs through, reversed at writeback
         end
         opSeq, opSlt, opSle, opSco: begin
            ctrl.regWrt = 1'b1;
            ctrl.regDest = dstRd;
            ctrl.setOp = 1'b1;
            ctrl.invB = (op != opSco);  // rs - rt for compares
            ctrl.Cin = (op != opSco);
         end
         default: illegal = 1'b1;       // unknown opcode bits
      endcase
      if (fnValid) begin
         if (shiftGrp) begin
            ctrl.aluOp = aluOpT'(3'(fn) + 3'(aluRol));  // rol, sll, ror, srl
         end else begin
            ctrl.aluOp = (fn == 2'b10) ? aluXor : (fn == 2'b11) ? aluAndn : aluAdd;
            ctrl.Cin = (fn == 2'b01);   // sub is B minus A
            ctrl.invA = (fn == 2'b01);
            ctrl.invB = (fn == 2'b11);  // andn
         end
      end
   end

endmodule

/* src/ctrlBusIf.sv */
//////////////////////////////
// control word from decoder to datapath
// modports per consuming block
//////////////////////////////
`timescale 1ns/100ps

interface ctrlBusIf import ctrlPkg::*; ();

   aluOpT aluOp;        // ALU function
   logic Cin;           // carry in, subtract
   logic invA;          // invert A, B minus A
   logic invB;          // invert B, andn and compare
   bSrcT bSrc;          // B operand source
   logic zeroSel;       // zero extend immediate
   brchCondT brchCond;  // branch or jump condition
   logic immSrc;        // imm11 into pc adder
   logic aluPc;         // next pc from ALU, JR/JALR
   logic regWrt;        // register write
   wbSrcT wbSrc;        // writeback source
   regDestT regDest;    // target register field
   logic setOp;         // set-on-condition result
   logic slbiOp;        // shift and merge imm8
   logic memWrt;        // data store
   logic stuSel;        // store data from rt

   modport ctrl (output aluOp, Cin, invA, invB, bSrc, zeroSel, brchCond, immSrc, aluPc,
                 regWrt, wbSrc, regDest, setOp, slbiOp, memWrt, stuSel);
   modport alu (input aluOp, Cin, invA, invB, bSrc, zeroSel);
   modport pc (input brchCond, immSrc, aluPc);
   modport wb (input regWrt, wbSrc, regDest, setOp, slbiOp);

endinterface

/* src/ctrlPkg.sv */
//////////////////////////////
// control package
// select enums, ALU op enum, ALU flag struct
//////////////////////////////
package ctrlPkg;

   typedef enum logic [1:0] {
      wbPcInc, wbMem, wbAlu, wbImm8
   } wbSrcT;

   typedef enum logic [1:0] {
      bReg, bImm5, bImm8, bZero
   } bSrcT;

   // rs target is needed by LBI, SLBI and STU
   typedef enum logic [1:0] {
      dstRs, dstRt, dstRd, dstR7
   } regDestT;

   typedef enum logic [2:0] {
      condNone = 3'b000,
      condSco  = 3'b001,   // carry
      condEq   = 3'b010,   // zero
      condGez  = 3'b011,   // not sign
      condLtz  = 3'b100,   // sign
      condNez  = 3'b101,   // not zero
      condLe   = 3'b110,   // zero or sign
      condJump = 3'b111    // always
   } brchCondT;

   typedef enum logic [2:0] {
      aluAdd, aluXor, aluAndn, aluRol, aluSll, aluRor, aluSrl
   } aluOpT;

   typedef struct packed {
      logic zero;
      logic sign;    // signed result below zero, overflow corrected
      logic carry;
   } aluFlagsT;

endpackage

/* src/isaPkg.sv */
//////////////////////////////
// ISA package
// word and register index widths
// opcode enum, instruction field positions
//////////////////////////////
package isaPkg;

   localparam int wordW = 16;     // data and instruction width
   localparam int regAddrW = 3;   // eight registers

   // all 32 codes are assigned, siic and RTI run as no-ops
   typedef enum logic [4:0] {
      opHalt, opNop, opSiic, opRti, opJ, opJr, opJal, opJalr,
      opAddi, opSubi, opXori, opAndni, opBeqz, opBnez, opBltz, opBgez,
      opSt, opLd, opSlbi, opStu, opRoli, opSlli, opRori, opSrli,
      opLbi, opBtr, opShiftR, opArithR, opSeq, opSlt, opSle, opSco
   } opcodeT;

   localparam int opMsb = 15;
   localparam int opLsb = 11;
   localparam int rsMsb = 10;     // first source, also LBI/SLBI/STU target
   localparam int rsLsb = 8;
   localparam int rtMsb = 7;      // second source, I-type target
   localparam int rtLsb = 5;
   localparam int rdMsb = 4;      // R-type target
   localparam int rdLsb = 2;
   localparam int imm5Msb = 4;    // immediates all start at bit 0
   localparam int imm8Msb = 7;
   localparam int imm11Msb = 10;
   localparam int fnMsb = 1;      // R-type function select
   localparam int fnLsb = 0;

endpackage
